//--- src.f
+incdir+include
hw/graph_pkg.sv
hw/vertex_memory.sv
hw/mem_arbiter.sv
hw/graph_cluster.sv
hw/kernel_control.sv
hw/graph_top.sv
testbench/tb_graph_top.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --timescale 1ns/1ps
TOP      = tb_graph_top
FILELIST = src.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: simulate clean

# Pass or fail comes from the log, not from the exit code
simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- testbench/tb_graph_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "graph_config.svh"

module tb_graph_top;

    import graph_pkg::*;

    localparam int NUM_TESTS   = 8;
    // Cycle budget of one test
    // Also the limit of a single wait
    localparam int TEST_CYCLES = `MEM_DEPTH * `NUM_CLUSTERS + 100;
    localparam int CNT_W       = `ADDR_W + 1;

    logic                            ap_clk;
    logic                            control_areset;
    control_in_t                     control_in;
    control_out_t                    control_out;
    descriptor_if_t                  descriptor_in;
    host_write_t                     host_write;
    vertex_sum_t [`NUM_CLUSTERS-1:0] cluster_sums;

    // Reference copy of the vertex memory
    vertex_data_t model_mem [`MEM_DEPTH];
    logic [31:0]  lcg_state;

    string test_name;
    int    errors;
    int    errors_at_start;
    int    tests_run;
    int    tests_failed;

    graph_top graph_top_i (
        .ap_clk         (ap_clk),
        .control_areset (control_areset),
        .control_in     (control_in),
        .control_out    (control_out),
        .descriptor_in  (descriptor_in),
        .host_write     (host_write),
        .cluster_sums   (cluster_sums)
    );

    // 8 ns clock
    initial ap_clk = 1'b0;
    always #4 ap_clk = ~ap_clk;

    // ----------------------------------------------------------
    // Random source and reference model
    // ----------------------------------------------------------

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Random base with a count from empty to full range
    function automatic graph_descriptor_t random_descriptor();
        logic [31:0] r;
        r = next_random();
        return '{base:  vertex_addr_t'(r[15:8]),
                 count: CNT_W'(32'(r[31:16]) % 32'(`MEM_DEPTH + 1))};
    endfunction

    // Random descriptor that gives every cluster at least one vertex
    function automatic graph_descriptor_t populated_descriptor();
        graph_descriptor_t d;
        d = random_descriptor();
        if (d.count < CNT_W'(`NUM_CLUSTERS)) begin
            d.count = CNT_W'(`NUM_CLUSTERS);
        end
        return d;
    endfunction

    // Cluster k owns offsets k, k+N, k+2N ... below count
    // Addresses wrap at the end of the memory
    function automatic vertex_sum_t expected_sum(input int k, input graph_descriptor_t d);
        vertex_sum_t acc;
        int          off;
        acc = '0;
        off = k;
        while (off < int'(d.count)) begin
            acc = acc + vertex_sum_t'(model_mem[vertex_addr_t'(int'(d.base) + off)]);
            off = off + `NUM_CLUSTERS;
        end
        return acc;
    endfunction

    // ----------------------------------------------------------
    // Compare tasks
    // ----------------------------------------------------------

    task automatic check_sum(input string name, input vertex_sum_t exp, input vertex_sum_t act);
        if (act !== exp) begin
            $display("Mismatch %s: expected %0h, actual %0h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_status(input string name, input control_out_t exp,
                                input control_out_t act);
        if (act !== exp) begin
            $display("Mismatch %s status (ready idle done): expected %b, actual %b",
                     name, exp, act);
            errors++;
        end
    endtask

    task automatic check_sums(input graph_descriptor_t d);
        // Empty slices come out of the model as zero
        for (int k = 0; k < `NUM_CLUSTERS; k++) begin
            check_sum($sformatf("%s sum[%0d]", test_name, k), expected_sum(k, d),
                      cluster_sums[k]);
        end
    endtask

    // ----------------------------------------------------------
    // Host side sequences
    // ----------------------------------------------------------

    // Whole memory gets fresh random words
    // One write per cycle
    task automatic load_memory();
        logic [31:0] r;
        for (int a = 0; a < `MEM_DEPTH; a++) begin
            r = next_random();
            host_write   = '{we: 1'b1, addr: vertex_addr_t'(a), data: r[31:16]};
            model_mem[a] = r[31:16];
            @(posedge ap_clk);
            #1;
        end
        host_write.we = 1'b0;
    endtask

    // Polls once per cycle since ready is only a one-cycle pulse
    task automatic wait_for_flag(input bit want_done);
        int cycles;
        cycles = 0;
        while ((want_done ? control_out.done : control_out.ready) !== 1'b1 &&
               cycles < TEST_CYCLES) begin
            @(posedge ap_clk);
            #1;
            cycles++;
        end
        if ((want_done ? control_out.done : control_out.ready) !== 1'b1) begin
            $display("Error in %s: %s did not rise within %0d cycles", test_name,
                     want_done ? "done" : "ready", TEST_CYCLES);
            errors++;
        end
    endtask

    // Strobe held until ready
    // Then run to done and check everything
    task automatic run_kernel(input bit use_continue, input graph_descriptor_t d);
        descriptor_in = '{valid: 1'b1, payload: d};
        if (use_continue) begin
            control_in.continue_run = 1'b1;
        end
        else begin
            control_in.start = 1'b1;
        end
        wait_for_flag(1'b0);
        control_in = '0;
        wait_for_flag(1'b1);
        check_status(test_name, '{ready: 1'b0, idle: 1'b1, done: 1'b1}, control_out);
        check_sums(d);
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == errors_at_start) begin
            $display("[ok]   %s", test_name);
        end
        else begin
            tests_failed++;
            $display("[FAIL] %s, %0d errors", test_name, errors - errors_at_start);
        end
    endtask

    // ----------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------

    initial begin
        graph_descriptor_t d;
        lcg_state      = 32'hd7c3_dae4;
        errors         = 0;
        tests_run      = 0;
        tests_failed   = 0;
        control_areset = 1'b1;
        control_in     = '0;
        descriptor_in  = '0;
        host_write     = '0;
        repeat (8) @(posedge ap_clk);
        #1;
        control_areset = 1'b0;

        begin_test("reset_status");
        check_status(test_name, '{ready: 1'b0, idle: 1'b1, done: 1'b0}, control_out);
        end_test();

        load_memory();
        for (int i = 0; i < 3; i++) begin
            begin_test($sformatf("random_run_%0d", i));
            run_kernel(1'b0, random_descriptor());
            end_test();
        end

        // Counts 0 to N-1 leave some clusters without work
        begin_test("small_count");
        for (int c = 0; c < `NUM_CLUSTERS; c++) begin
            d       = random_descriptor();
            d.count = CNT_W'(c);
            run_kernel(1'b0, d);
        end
        end_test();

        // Second run from done
        // Sums must not carry over
        begin_test("continue_run");
        run_kernel(1'b0, populated_descriptor());
        run_kernel(1'b1, random_descriptor());
        end_test();

        begin_test("rewrite_rerun");
        d = populated_descriptor();
        run_kernel(1'b0, d);
        load_memory();
        run_kernel(1'b0, d);
        end_test();

        // Every cluster busy for full arbiter contention
        begin_test("full_range");
        run_kernel(1'b0, '{base: '0, count: CNT_W'(`MEM_DEPTH)});
        end_test();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("sim passed");
        end
        else begin
            $display("sim failed");
        end
        $finish;
    end

    // Watchdog budget scales with the number of tests
    initial begin
        repeat (NUM_TESTS * TEST_CYCLES) @(posedge ap_clk);
        $display("Timeout: tests did not finish within %0d cycles", NUM_TESTS * TEST_CYCLES);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/graph_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "graph_config.svh"

module graph_top (
    input  wire logic                                        ap_clk,
    input  wire logic                                        control_areset,
    input  wire graph_pkg::control_in_t                      control_in,
    output wire graph_pkg::control_out_t                     control_out,
    input  wire graph_pkg::descriptor_if_t                   descriptor_in,
    input  wire graph_pkg::host_write_t                      host_write,
    output wire graph_pkg::vertex_sum_t [`NUM_CLUSTERS-1:0]  cluster_sums
);

    import graph_pkg::*;

    wire descriptor_if_t                   descriptor;
    wire cluster_mask_t                    cu_setup;
    wire cluster_mask_t                    cu_done;
    wire mem_req_t [`NUM_CLUSTERS-1:0]     reqs;
    wire cluster_mask_t                    grant;
    wire cluster_mask_t                    rvalid;
    wire vertex_addr_t                     rd_addr;
    // Broadcast to every cluster, rvalid picks the owner
    wire vertex_data_t                     rd_data;

    // ----------------------------------------------------------
    // Control chain
    // ----------------------------------------------------------

    kernel_control kernel_control_i (
        .ap_clk         (ap_clk),
        .control_areset (control_areset),
        .cu_done        (cu_done),
        .cu_setup       (cu_setup),
        .control_in     (control_in),
        .control_out    (control_out),
        .descriptor_in  (descriptor_in),
        .descriptor_out (descriptor)
    );

    // ----------------------------------------------------------
    // Clusters
    // ----------------------------------------------------------

    for (genvar k = 0; k < `NUM_CLUSTERS; k++) begin : g_cluster
        graph_cluster #(
            .CLUSTER_ID (k)
        ) graph_cluster_i (
            .ap_clk         (ap_clk),
            .control_areset (control_areset),
            .descriptor     (descriptor),
            .mem_req        (reqs[k]),
            .grant          (grant[k]),
            .rvalid         (rvalid[k]),
            .rdata          (rd_data),
            .setup          (cu_setup[k]),
            .done           (cu_done[k]),
            .sum            (cluster_sums[k])
        );
    end

    // ----------------------------------------------------------
    // Shared vertex memory
    // ----------------------------------------------------------

    mem_arbiter mem_arbiter_i (
        .ap_clk         (ap_clk),
        .control_areset (control_areset),
        .reqs           (reqs),
        .grant          (grant),
        .rd_addr        (rd_addr),
        .rvalid         (rvalid)
    );

    vertex_memory vertex_memory_i (
        .ap_clk     (ap_clk),
        .host_write (host_write),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)
    );

endmodule

`default_nettype wire

//--- hw/kernel_control.sv
`timescale 1ns/1ps
`default_nettype none

module kernel_control (
    input  wire logic                      ap_clk,
    input  wire logic                      control_areset,
    input  wire graph_pkg::cluster_mask_t  cu_done,
    input  wire graph_pkg::cluster_mask_t  cu_setup,
    input  wire graph_pkg::control_in_t    control_in,
    output graph_pkg::control_out_t        control_out,
    input  wire graph_pkg::descriptor_if_t descriptor_in,
    output graph_pkg::descriptor_if_t      descriptor_out
);

    import graph_pkg::*;

    logic              areset_q;
    cluster_mask_t     cu_done_q;
    cluster_mask_t     cu_setup_q;
    logic              start_q;
    logic              continue_q;

    // Status decoded from the state
    logic              ready_q;
    logic              idle_q;
    logic              done_q;
    logic              desc_valid_q;

    // Output stage
    logic              desc_valid_out_q;
    graph_descriptor_t payload_q;

    control_state_t    current_state;
    control_state_t    next_state;

    // ----------------------------------------------------------
    // Reset and input registers
    // ----------------------------------------------------------

    always_ff @(posedge ap_clk) begin
        areset_q <= control_areset;
    end

    // Setup bits read as busy until the clusters come up
    always_ff @(posedge ap_clk) begin
        if (areset_q) begin
            cu_done_q  <= '0;
            cu_setup_q <= '1;
            start_q    <= 1'b0;
            continue_q <= 1'b0;
        end
        else begin
            cu_done_q  <= cu_done;
            cu_setup_q <= cu_setup;
            start_q    <= control_in.start;
            continue_q <= control_in.continue_run;
        end
    end

    // ----------------------------------------------------------
    // Control chain FSM
    // ----------------------------------------------------------

    always_ff @(posedge ap_clk) begin
        if (areset_q) begin
            current_state <= CTRL_RESET;
        end
        else begin
            current_state <= next_state;
        end
    end

    always_comb begin
        next_state = current_state;
        case (current_state)
            CTRL_RESET: next_state = CTRL_IDLE;
            CTRL_IDLE:  next_state = CTRL_SETUP;
            // Start only once every cluster left setup
            CTRL_SETUP: begin
                if (start_q && !(|cu_setup_q)) begin
                    next_state = CTRL_READY;
                end
            end
            CTRL_READY: next_state = CTRL_START;
            CTRL_START: next_state = CTRL_BUSY;
            CTRL_BUSY: begin
                if (&cu_done_q) begin
                    next_state = CTRL_DONE;
                end
            end
            // Stale done bits must clear before a new run
            CTRL_DONE: begin
                if ((start_q || continue_q) && !(|cu_done_q)) begin
                    next_state = CTRL_READY;
                end
            end
            default: next_state = CTRL_RESET;
        endcase
    end

    // ----------------------------------------------------------
    // Status decode
    // ----------------------------------------------------------

    always_ff @(posedge ap_clk) begin
        if (areset_q) begin
            ready_q      <= 1'b0;
            idle_q       <= 1'b1;
            done_q       <= 1'b0;
            desc_valid_q <= 1'b0;
        end
        else begin
            ready_q      <= (current_state == CTRL_READY);
            // Idle before a run and again once it is done
            idle_q       <= (current_state == CTRL_RESET) ||
                            (current_state == CTRL_IDLE)  ||
                            (current_state == CTRL_SETUP) ||
                            (current_state == CTRL_DONE);
            done_q       <= (current_state == CTRL_DONE);
            // Clusters run while valid stays high
            desc_valid_q <= (current_state == CTRL_START) ||
                            (current_state == CTRL_BUSY);
        end
    end

    // ----------------------------------------------------------
    // Output stage
    // ----------------------------------------------------------

    always_ff @(posedge ap_clk) begin
        if (areset_q) begin
            control_out      <= '{ready: 1'b0, idle: 1'b1, done: 1'b0};
            desc_valid_out_q <= 1'b0;
        end
        else begin
            control_out      <= '{ready: ready_q, idle: idle_q, done: done_q};
            desc_valid_out_q <= desc_valid_q;
        end
    end

    // Payload taken in the ready cycle and held through the run
    always_ff @(posedge ap_clk) begin
        if (current_state == CTRL_READY && descriptor_in.valid) begin
            payload_q <= descriptor_in.payload;
        end
    end

    assign descriptor_out = '{valid: desc_valid_out_q, payload: payload_q};

endmodule

`default_nettype wire

//--- hw/graph_cluster.sv
`timescale 1ns/1ps
`default_nettype none

`include "graph_config.svh"

module graph_cluster #(
    parameter int CLUSTER_ID = 0
) (
    input  wire logic                      ap_clk,
    input  wire logic                      control_areset,
    input  wire graph_pkg::descriptor_if_t descriptor,
    output graph_pkg::mem_req_t            mem_req,
    input  wire logic                      grant,
    input  wire logic                      rvalid,
    input  wire graph_pkg::vertex_data_t   rdata,
    output logic                           setup,
    output logic                           done,
    output graph_pkg::vertex_sum_t         sum
);

    import graph_pkg::*;

    // Interleaved slice, start at own index and step by cluster count
    localparam logic [`ADDR_W:0] FIRST_OFFSET = (`ADDR_W + 1)'(CLUSTER_ID);
    localparam logic [`ADDR_W:0] STRIDE       = (`ADDR_W + 1)'(`NUM_CLUSTERS);

    cluster_state_t   state;
    // For the rising edge of descriptor valid
    logic             valid_q;
    logic             run_start;
    // Offset from base of the next read
    logic [`ADDR_W:0] offset;
    logic [`ADDR_W:0] next_offset;
    // Reads granted but not yet returned
    logic [1:0]       pending;
    logic             issue;

    assign run_start   = descriptor.valid & ~valid_q;
    assign issue       = (state == WALK) & grant;
    assign next_offset = offset + STRIDE;

    // Request held until granted, address wraps inside the memory
    assign mem_req = '{
        req:  (state == WALK),
        addr: descriptor.payload.base + offset[`ADDR_W-1:0]
    };

    assign done = (state == DONE);

    // ----------------------------------------------------------
    // Setup flag
    // ----------------------------------------------------------

    // Low one cycle after reset drops
    always_ff @(posedge ap_clk) begin
        if (control_areset) begin
            setup <= 1'b1;
        end
        else begin
            setup <= 1'b0;
        end
    end

    // ----------------------------------------------------------
    // Walk FSM and accumulator
    // ----------------------------------------------------------

    always_ff @(posedge ap_clk) begin
        if (control_areset) begin
            state   <= IDLE;
            valid_q <= 1'b0;
            offset  <= FIRST_OFFSET;
            pending <= '0;
            sum     <= '0;
        end
        else begin
            valid_q <= descriptor.valid;
            pending <= pending + 2'(issue) - 2'(rvalid);
            // Returned word belongs to this cluster
            if (rvalid) begin
                sum <= sum + vertex_sum_t'(rdata);
            end
            case (state)
                IDLE: begin
                    if (run_start) begin
                        sum    <= '0;
                        offset <= FIRST_OFFSET;
                        // Empty slice finishes at once
                        state  <= (FIRST_OFFSET < descriptor.payload.count) ? WALK : DONE;
                    end
                end
                WALK: begin
                    if (grant) begin
                        offset <= next_offset;
                        if (next_offset >= descriptor.payload.count) begin
                            state <= DRAIN;
                        end
                    end
                end
                // Wait for the last read to come back
                DRAIN: begin
                    if (pending == '0) begin
                        state <= DONE;
                    end
                end
                // Held until the control block drops valid
                DONE: begin
                    if (!descriptor.valid) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "graph_config.svh"

module mem_arbiter (
    input  wire logic                                        ap_clk,
    input  wire logic                                        control_areset,
    input  wire graph_pkg::mem_req_t [`NUM_CLUSTERS-1:0]     reqs,
    output graph_pkg::cluster_mask_t                         grant,
    output graph_pkg::vertex_addr_t                          rd_addr,
    output graph_pkg::cluster_mask_t                         rvalid
);

    import graph_pkg::*;

    localparam int N     = `NUM_CLUSTERS;
    localparam int IDX_W = (N > 1) ? $clog2(N) : 1;

    // Highest priority requester for this cycle
    logic [IDX_W-1:0] ptr;
    // Winning requester
    logic [IDX_W-1:0] sel;
    logic             found;

    // ----------------------------------------------------------
    // Round-robin pick
    // ----------------------------------------------------------

    // Scan from the pointer upward and wrap
    always_comb begin
        int idx;
        grant = '0;
        sel   = ptr;
        found = 1'b0;
        for (int i = 0; i < N; i++) begin
            idx = (int'(ptr) + i) % N;
            if (!found && reqs[idx].req) begin
                found      = 1'b1;
                sel        = IDX_W'(idx);
                grant[idx] = 1'b1;
            end
        end
    end

    // Winner's address straight to the RAM
    assign rd_addr = reqs[sel].addr;

    // ----------------------------------------------------------
    // Pointer and read return
    // ----------------------------------------------------------

    // Pointer moves past the last winner
    // Data tag is the grant delayed by one cycle
    always_ff @(posedge ap_clk) begin
        if (control_areset) begin
            ptr    <= '0;
            rvalid <= '0;
        end
        else begin
            if (found) begin
                ptr <= (sel == IDX_W'(N - 1)) ? '0 : sel + 1'b1;
            end
            rvalid <= grant;
        end
    end

endmodule

`default_nettype wire

//--- hw/vertex_memory.sv
`timescale 1ns/1ps
`default_nettype none

`include "graph_config.svh"

module vertex_memory (
    input  wire logic                   ap_clk,
    input  wire graph_pkg::host_write_t host_write,
    input  wire graph_pkg::vertex_addr_t rd_addr,
    output graph_pkg::vertex_data_t     rd_data
);

    import graph_pkg::*;

    // Vertex storage, no reset on the array
    vertex_data_t mem [`MEM_DEPTH];

    // ----------------------------------------------------------
    // Host write side
    // ----------------------------------------------------------

    // Host only writes while the kernel reports idle
    always_ff @(posedge ap_clk) begin
        if (host_write.we) begin
            mem[host_write.addr] <= host_write.data;
        end
    end

    // ----------------------------------------------------------
    // Arbitrated read side
    // ----------------------------------------------------------

    // One cycle read latency
    // Data returns on the cycle after the grant
    always_ff @(posedge ap_clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

//--- hw/graph_pkg.sv
`default_nettype none

`include "graph_config.svh"

package graph_pkg;

    // ----------------------------------------------------------
    // Width types
    // ----------------------------------------------------------

    typedef logic [`ADDR_W-1:0]       vertex_addr_t;
    typedef logic [`DATA_W-1:0]       vertex_data_t;
    typedef logic [`SUM_W-1:0]        vertex_sum_t;
    // One bit per cluster
    typedef logic [`NUM_CLUSTERS-1:0] cluster_mask_t;

    // ----------------------------------------------------------
    // Descriptor and control chain
    // ----------------------------------------------------------

    // Count is one bit wider so a full-range run fits
    typedef struct packed {
        vertex_addr_t     base;
        logic [`ADDR_W:0] count;
    } graph_descriptor_t;

    typedef struct packed {
        logic              valid;
        graph_descriptor_t payload;
    } descriptor_if_t;

    typedef struct packed {
        logic start;
        logic continue_run;
    } control_in_t;

    typedef struct packed {
        logic ready;
        logic idle;
        logic done;
    } control_out_t;

    // ----------------------------------------------------------
    // Memory side
    // ----------------------------------------------------------

    typedef struct packed {
        logic         req;
        vertex_addr_t addr;
    } mem_req_t;

    typedef struct packed {
        logic         we;
        vertex_addr_t addr;
        vertex_data_t data;
    } host_write_t;

    // ----------------------------------------------------------
    // State machines
    // ----------------------------------------------------------

    typedef enum logic [2:0] {
        CTRL_RESET,
        CTRL_IDLE,
        CTRL_SETUP,
        CTRL_READY,
        CTRL_START,
        CTRL_BUSY,
        CTRL_DONE
    } control_state_t;

    typedef enum logic [1:0] {
        IDLE,
        WALK,
        DRAIN,
        DONE
    } cluster_state_t;

endpackage

`default_nettype wire

//--- include/graph_config.svh
`ifndef GRAPH_CONFIG_SVH
`define GRAPH_CONFIG_SVH

// ----------------------------------------------------------
// Overlay sizing
// ----------------------------------------------------------

// Number of graph clusters sharing the vertex memory
`define NUM_CLUSTERS 4

// ----------------------------------------------------------
// Bus widths
// ----------------------------------------------------------

// Vertex address, covers the whole vertex memory
`define ADDR_W 8

// One vertex value
`define DATA_W 16

// Per-cluster accumulator, headroom for a full-range run
`define SUM_W 24

// Words in the vertex memory
`define MEM_DEPTH 256

`endif
